/* dmem_port.f */
mem_types_pkg.sv
mem_map_pkg.sv
walk_read_seq.sv
data_port_arbiter.sv
dmem_port.sv
tb_dcache_model.sv
tb_dmem_port.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dmem_port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_dmem_port \
    -f dmem_port.f \
    -o sim_dmem_port

./obj_dir/sim_dmem_port > sim.log 2>&1
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_dmem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_port;

    import mem_types_pkg::*;
    import mem_map_pkg::*;

    localparam int     CLK_PERIOD   = 100;
    localparam int     NUM_TESTS    = 6;
    localparam int     TEST_CYCLES  = 200;
    localparam dword_t DATA_PATTERN = 64'ha5a5_a5a5_a5a5_a5a5;

    typedef logic [129:0] chk_t;

    logic          CLK;
    logic          RSTN;
    dport_req_t    proc_req;
    logic          proc_ready;
    logic          itlb_walk_req;
    addr_t         itlb_walk_addr;
    walk_resp_t    itlb_walk_resp;
    logic          dtlb_walk_req;
    addr_t         dtlb_walk_addr;
    walk_resp_t    dtlb_walk_resp;
    dport_req_t    cache_req;
    logic          cache_ready;
    dword_t        cache_rdata;
    logic          console_valid;
    console_byte_t console_byte;
    logic          stall_en;
    dport_req_t    last_req;
    int            errors;
    int            tests_passed;
    int            tests_failed;

    dmem_port dut_i (
        .CLK(CLK), .RSTN(RSTN),
        .proc_req(proc_req), .proc_ready(proc_ready),
        .itlb_walk_req(itlb_walk_req), .itlb_walk_addr(itlb_walk_addr),
        .itlb_walk_resp(itlb_walk_resp),
        .dtlb_walk_req(dtlb_walk_req), .dtlb_walk_addr(dtlb_walk_addr),
        .dtlb_walk_resp(dtlb_walk_resp),
        .cache_req(cache_req), .cache_ready(cache_ready), .cache_rdata(cache_rdata),
        .console_valid(console_valid), .console_byte(console_byte)
    );

    tb_dcache_model cache_i (
        .CLK(CLK), .RSTN(RSTN), .req(cache_req), .stall_en(stall_en),
        .ready(cache_ready), .rdata(cache_rdata), .last_req(last_req)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    ////////////////////
    // helpers
    ////////////////////

    // data the cache model returns for a load
    function automatic dword_t expected_rdata(addr_t addr);
        return addr ^ DATA_PATTERN;
    endfunction

    // dword aligned, never the console
    function automatic addr_t random_addr();
        addr_t addr;
        addr = {$urandom, $urandom};
        addr[2:0] = 3'b000;
        if (addr == CONSOLE_ADDR) begin
            addr = addr + addr_t'(8);
        end
        return addr;
    endfunction

    task automatic check(input string name, input chk_t expected, input chk_t actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // one settle cycle so the model picks up the new mode cleanly
    task automatic set_stall(input logic enable);
        @(negedge CLK);
        stall_en = enable;
        @(negedge CLK);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset();
        int base;
        base = errors;
        @(posedge CLK);
        check("reset itlb valid", chk_t'(0), chk_t'(itlb_walk_resp.valid));
        check("reset dtlb valid", chk_t'(0), chk_t'(dtlb_walk_resp.valid));
        check("reset console valid", chk_t'(0), chk_t'(console_valid));
        check("reset proc_ready", chk_t'(cache_ready), chk_t'(proc_ready));
        close_test("reset", base);
    endtask

    task automatic test_passthrough();
        int         base;
        dport_req_t req;
        dport_req_t prev;
        base = errors;
        prev = '0;
        for (int i = 0; i < 9; i++) begin
            @(negedge CLK);
            req.op    = ($urandom % 2 == 0) ? MEM_LOAD : MEM_STORE;
            req.addr  = random_addr();
            req.wdata = {$urandom, $urandom};
            proc_req  = (i < 8) ? req : '0;
            @(posedge CLK);
            check("passthrough cache_req", chk_t'(proc_req), chk_t'(cache_req));
            check("passthrough proc_ready", chk_t'(1), chk_t'(proc_ready));
            // the previous request has been accepted by now
            if (i > 0) begin
                check("passthrough last request", chk_t'(prev), chk_t'(last_req));
                if (prev.op == MEM_LOAD) begin
                    check("passthrough load data", chk_t'(expected_rdata(prev.addr)),
                          chk_t'(cache_rdata));
                end
            end
            prev = proc_req;
        end
        close_test("passthrough", base);
    endtask

    task automatic test_console();
        int     base;
        dword_t wdata;
        base  = errors;
        wdata = {$urandom, $urandom};
        @(negedge CLK);
        proc_req = '{op: MEM_STORE, addr: CONSOLE_ADDR, wdata: wdata};
        @(posedge CLK);
        check("console store op", chk_t'(MEM_NONE), chk_t'(cache_req.op));
        check("console early strobe", chk_t'(0), chk_t'(console_valid));
        @(negedge CLK);
        proc_req = '{op: MEM_LOAD, addr: CONSOLE_ADDR, wdata: '0};
        @(posedge CLK);
        check("console strobe", chk_t'(1), chk_t'(console_valid));
        check("console byte", chk_t'(wdata[7:0]), chk_t'(console_byte));
        check("console load op", chk_t'(MEM_NONE), chk_t'(cache_req.op));
        @(negedge CLK);
        proc_req = '0;
        @(posedge CLK);
        // single pulse, and the load gives none
        check("console strobe after load", chk_t'(0), chk_t'(console_valid));
        close_test("console", base);
    endtask

    task automatic test_itlb_walk();
        int    base;
        int    cycles;
        int    loads;
        addr_t addr;
        base   = errors;
        cycles = 0;
        loads  = 0;
        addr   = random_addr();
        @(negedge CLK);
        itlb_walk_req  = 1'b1;
        itlb_walk_addr = addr;
        @(posedge CLK);
        @(negedge CLK);
        itlb_walk_req  = 1'b0;
        itlb_walk_addr = '0;
        do begin
            @(posedge CLK);
            cycles++;
            if (cache_req.op == MEM_LOAD) begin
                loads++;
                check("itlb walk load addr", chk_t'(addr), chk_t'(cache_req.addr));
                check("itlb walk proc_ready", chk_t'(0), chk_t'(proc_ready));
            end
        end while (!itlb_walk_resp.valid && cycles < TEST_CYCLES);
        if (!itlb_walk_resp.valid) begin
            $display("itlb walk: the response never became valid");
            errors++;
        end else begin
            // no stalls, so wait cycles plus the issue cycle
            check("itlb walk latency", chk_t'(int'(ITLB_WALK_WAIT) + 1), chk_t'(cycles));
            check("itlb walk load count", chk_t'(1), chk_t'(loads));
            check("itlb walk data", chk_t'(expected_rdata(addr)), chk_t'(itlb_walk_resp.data));
        end
        close_test("itlb_walk", base);
    endtask

    task automatic test_dtlb_stall();
        int    base;
        int    cycles;
        int    ready_cycles;
        logic  seen;
        addr_t addr;
        base   = errors;
        cycles = 0;
        seen   = 1'b0;
        addr   = random_addr();
        set_stall(1'b1);
        dtlb_walk_req  = 1'b1;
        dtlb_walk_addr = addr;
        @(posedge CLK);
        // the strobe cycle counts as the first
        ready_cycles = 1;
        @(negedge CLK);
        dtlb_walk_req = 1'b0;
        while (!seen && cycles < TEST_CYCLES) begin
            @(posedge CLK);
            cycles++;
            if (dtlb_walk_resp.valid) begin
                seen = 1'b1;
            end else if (cache_ready) begin
                ready_cycles++;
            end
        end
        if (!seen) begin
            $display("dtlb walk under stalls: the response never became valid");
            errors++;
        end else begin
            check("dtlb walk ready cycles", chk_t'(int'(DTLB_WALK_WAIT) + 1),
                  chk_t'(ready_cycles));
            check("dtlb walk data", chk_t'(expected_rdata(addr)), chk_t'(dtlb_walk_resp.data));
        end
        set_stall(1'b0);
        close_test("dtlb_stall", base);
    endtask

    task automatic test_priority();
        int         base;
        int         cycles;
        dport_req_t proc_load;
        dport_req_t walk_load;
        base      = errors;
        cycles    = 0;
        proc_load = '{op: MEM_LOAD, addr: random_addr(), wdata: '0};
        walk_load = '{op: MEM_LOAD, addr: random_addr(), wdata: '0};
        @(negedge CLK);
        proc_req       = proc_load;
        dtlb_walk_req  = 1'b1;
        dtlb_walk_addr = walk_load.addr;
        @(posedge CLK);
        check("priority strobe cycle req", chk_t'(proc_load), chk_t'(cache_req));
        @(negedge CLK);
        dtlb_walk_req = 1'b0;
        @(posedge CLK);
        check("priority walk req", chk_t'(walk_load), chk_t'(cache_req));
        check("priority walk proc_ready", chk_t'(0), chk_t'(proc_ready));
        @(posedge CLK);
        check("priority proc req", chk_t'(proc_load), chk_t'(cache_req));
        check("priority proc_ready", chk_t'(1), chk_t'(proc_ready));
        @(negedge CLK);
        proc_req = '0;
        // let the walk finish so the sequencer is idle again
        while (!dtlb_walk_resp.valid && cycles < TEST_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        if (!dtlb_walk_resp.valid) begin
            $display("priority: the dtlb walk never finished");
            errors++;
        end
        close_test("priority", base);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        void'($urandom(11));
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        RSTN           = 1'b0;
        proc_req       = '0;
        itlb_walk_req  = 1'b0;
        itlb_walk_addr = '0;
        dtlb_walk_req  = 1'b0;
        dtlb_walk_addr = '0;
        stall_en       = 1'b0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RSTN = 1'b1;
        test_reset();
        test_passthrough();
        test_console();
        test_itlb_walk();
        test_dtlb_stall();
        test_priority();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog: the run took more than %0d cycles and was stopped",
                 NUM_TESTS * TEST_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_dcache_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_model (
    input  wire                             CLK,
    input  wire                             RSTN,
    input  wire mem_types_pkg::dport_req_t  req,
    input  wire                             stall_en,
    output logic                            ready,
    output mem_types_pkg::dword_t           rdata,
    output mem_types_pkg::dport_req_t       last_req
);

    import mem_types_pkg::*;

    localparam dword_t DATA_PATTERN = 64'ha5a5_a5a5_a5a5_a5a5;

    logic       ready_q = 1'b1;
    dword_t     rdata_q = '0;
    dport_req_t last_q  = '0;

    // ready moves with the other inputs, on the falling edge
    always @(negedge CLK) begin
        ready_q <= stall_en ? ($urandom % 2 == 0) : 1'b1;
    end

    always @(posedge CLK) begin
        if (!RSTN) begin
            rdata_q <= '0;
            last_q  <= '0;
        end else if (ready_q && (req.op != MEM_NONE)) begin
            last_q <= req;
            if (req.op == MEM_LOAD) begin
                rdata_q <= req.addr ^ DATA_PATTERN;
            end
        end
    end

    assign ready    = ready_q;
    assign rdata    = rdata_q;
    assign last_req = last_q;

endmodule

`default_nettype wire

/* dmem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_port (
    input  wire                             CLK,
    input  wire                             RSTN,
    input  wire mem_types_pkg::dport_req_t  proc_req,
    output logic                            proc_ready,
    input  wire                             itlb_walk_req,
    input  wire mem_types_pkg::addr_t       itlb_walk_addr,
    output mem_types_pkg::walk_resp_t       itlb_walk_resp,
    input  wire                             dtlb_walk_req,
    input  wire mem_types_pkg::addr_t       dtlb_walk_addr,
    output mem_types_pkg::walk_resp_t       dtlb_walk_resp,
    output mem_types_pkg::dport_req_t       cache_req,
    input  wire                             cache_ready,
    input  wire mem_types_pkg::dword_t      cache_rdata,
    output logic                            console_valid,
    output mem_types_pkg::console_byte_t    console_byte
);

    import mem_types_pkg::*;
    import mem_map_pkg::*;

    // walk loads headed for the port mux
    logic  itlb_issue;
    addr_t itlb_addr;
    logic  dtlb_issue;
    addr_t dtlb_addr;

    walk_read_seq #(
        .WALK_WAIT     (ITLB_WALK_WAIT)
    ) itlb_walk_i (
        .CLK           (CLK),
        .RSTN          (RSTN),
        .walk_req      (itlb_walk_req),
        .walk_req_addr (itlb_walk_addr),
        .cache_ready   (cache_ready),
        .cache_rdata   (cache_rdata),
        .walk_issue    (itlb_issue),
        .walk_addr     (itlb_addr),
        .walk_resp     (itlb_walk_resp)
    );

    walk_read_seq #(
        .WALK_WAIT     (DTLB_WALK_WAIT)
    ) dtlb_walk_i (
        .CLK           (CLK),
        .RSTN          (RSTN),
        .walk_req      (dtlb_walk_req),
        .walk_req_addr (dtlb_walk_addr),
        .cache_ready   (cache_ready),
        .cache_rdata   (cache_rdata),
        .walk_issue    (dtlb_issue),
        .walk_addr     (dtlb_addr),
        .walk_resp     (dtlb_walk_resp)
    );

    data_port_arbiter arbiter_i (
        .CLK           (CLK),
        .RSTN          (RSTN),
        .proc_req      (proc_req),
        .proc_ready    (proc_ready),
        .itlb_issue    (itlb_issue),
        .itlb_addr     (itlb_addr),
        .dtlb_issue    (dtlb_issue),
        .dtlb_addr     (dtlb_addr),
        .cache_ready   (cache_ready),
        .cache_req     (cache_req),
        .console_valid (console_valid),
        .console_byte  (console_byte)
    );

endmodule

`default_nettype wire

/* data_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module data_port_arbiter (
    input  wire                             CLK,
    input  wire                             RSTN,
    input  wire mem_types_pkg::dport_req_t  proc_req,
    output logic                            proc_ready,
    input  wire                             itlb_issue,
    input  wire mem_types_pkg::addr_t       itlb_addr,
    input  wire                             dtlb_issue,
    input  wire mem_types_pkg::addr_t       dtlb_addr,
    input  wire                             cache_ready,
    output mem_types_pkg::dport_req_t       cache_req,
    output logic                            console_valid,
    output mem_types_pkg::console_byte_t    console_byte
);

    import mem_types_pkg::*;
    import mem_map_pkg::*;

    logic       walk_busy;
    logic       console_hit;
    logic       console_fire;
    dport_req_t proc_fwd;

    assign walk_busy   = dtlb_issue | itlb_issue;
    assign console_hit = (proc_req.addr == CONSOLE_ADDR);

    ////////////////////
    // processor side
    ////////////////////

    // console accesses never reach the cache
    always_comb begin
        proc_fwd = proc_req;
        if (console_hit) begin
            proc_fwd.op = MEM_NONE;
        end
    end

    // processor stalls while a walk load owns the port
    assign proc_ready = cache_ready & ~walk_busy;

    ////////////////////
    // port mux
    ////////////////////

    // dtlb first, then itlb, then the processor
    always_comb begin
        if (dtlb_issue) begin
            cache_req = '{op: MEM_LOAD, addr: dtlb_addr, wdata: '0};
        end else if (itlb_issue) begin
            cache_req = '{op: MEM_LOAD, addr: itlb_addr, wdata: '0};
        end else begin
            cache_req = proc_fwd;
        end
    end

    ////////////////////
    // console tap
    ////////////////////

    // only once the processor actually advances past the store
    assign console_fire = console_hit && (proc_req.op == MEM_STORE) && proc_ready;

    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            console_valid <= 1'b0;
        end else begin
            console_valid <= console_fire;
        end
    end

    // low byte carries the character
    always_ff @(posedge CLK) begin
        if (console_fire) begin
            console_byte <= console_byte_t'(proc_req.wdata);
        end
    end

endmodule

`default_nettype wire

/* walk_read_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module walk_read_seq #(
    parameter mem_map_pkg::walk_cnt_t WALK_WAIT = mem_map_pkg::DTLB_WALK_WAIT
) (
    input  wire                        CLK,
    input  wire                        RSTN,
    input  wire                        walk_req,
    input  wire mem_types_pkg::addr_t  walk_req_addr,
    input  wire                        cache_ready,
    input  wire mem_types_pkg::dword_t cache_rdata,
    output logic                       walk_issue,
    output mem_types_pkg::addr_t       walk_addr,
    output mem_types_pkg::walk_resp_t  walk_resp
);

    import mem_types_pkg::*;
    import mem_map_pkg::*;

    walk_cnt_t walk_cnt;
    logic      walk_done;
    logic      resp_valid;
    dword_t    resp_data;

    // last ready cycle of the wait, read data is on the cache port now
    assign walk_done = cache_ready && (walk_cnt == WALK_WAIT);

    ////////////////////
    // issue and wait counter
    ////////////////////

    always_ff @(posedge CLK) begin
        if (!RSTN) begin
            walk_issue <= 1'b0;
            walk_cnt   <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (walk_req) begin
                walk_issue <= 1'b1;
                walk_cnt   <= walk_cnt_t'(1);
            end else if (cache_ready) begin
                // the load is taken on this ready cycle
                walk_issue <= 1'b0;
                if (walk_done) begin
                    walk_cnt   <= '0;
                    resp_valid <= 1'b1;
                end else if (walk_cnt != '0) begin
                    walk_cnt <= walk_cnt + walk_cnt_t'(1);
                end
            end
        end
    end

    ////////////////////
    // address and read data
    ////////////////////

    always_ff @(posedge CLK) begin
        if (walk_req) begin
            walk_addr <= walk_req_addr;
        end
        if (walk_done) begin
            resp_data <= cache_rdata;
        end
    end

    assign walk_resp = '{valid: resp_valid, data: resp_data};

endmodule

`default_nettype wire

/* mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // width of the walk wait counters
    typedef logic [2:0] walk_cnt_t;

    // byte stores here go to the console, not the cache
    localparam mem_types_pkg::addr_t CONSOLE_ADDR = 64'h0000_0000_e000_1030;

    // ready cycles before a walk read is taken from the cache
    localparam walk_cnt_t ITLB_WALK_WAIT = 3'd5;
    localparam walk_cnt_t DTLB_WALK_WAIT = 3'd4;

endpackage

`default_nettype wire

/* mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

    localparam int ADDR_W    = 64;
    localparam int DWORD_W   = 64;
    localparam int CONSOLE_W = 8;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DWORD_W-1:0]   dword_t;
    typedef logic [CONSOLE_W-1:0] console_byte_t;

    // same 0/1/2 control code the data cache decodes
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_t;

    // one request on the shared data port
    typedef struct packed {
        mem_op_t op;
        addr_t   addr;
        dword_t  wdata;
    } dport_req_t;

    typedef struct packed {
        logic   valid;
        dword_t data;
    } walk_resp_t;

endpackage

`default_nettype wire
